// File: Bender.yml
package:
  name: snes_map

sources:
  - common/snes_map_pkg.sv
  - hdl/snes_bus_capture.sv
  - address_map/rom_map.sv
  - address_map/reg_decode.sv
  - hdl/mem_req_issue.sv
  - hdl/snes_map_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/snes_map_props.sv
      - testbench/tb_snes_map.sv

// File: address_map/reg_decode.sv
`timescale 1ns/10ps

// Peripheral and command-region selects, registered one stage
module reg_decode import snes_map_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  map_cfg_t    cfg,
  input  logic        cyc_valid,
  input  bus_cycle_t  cyc,
  output logic        sel_valid,
  output periph_sel_t sel
);

  periph_sel_t dec;
  logic [23:0] a;

  assign a = cyc.addr;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // 2000-2007 in any bank below 40
  assign dec.msu = cfg.featurebits[FEAT_MSU1] & !a[22] & (a[15:3] == 13'h0400);
  assign dec.r213f = cfg.featurebits[FEAT_213F] & (cyc.pa == 8'h3f);
  assign dec.r2100 = (cyc.pa == 8'h00);
  assign dec.obc1 = !a[22] & (a[15:11] == 5'b01111);
  assign dec.snescmd = !a[22] & (a[15:9] == 7'b0010101);

  // Exact hook addresses
  assign dec.nmicmd        = (a == 24'h002BF2);
  assign dec.return_vector = (a == 24'h002A6C);
  assign dec.branch1       = (a == 24'h002A1F);
  assign dec.branch2       = (a == 24'h002A59);
  assign dec.branch3       = (a == 24'h002A5E);

  ////////////////////////////////////////
  // Stage register, lines up with enqueue
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_valid <= 1'b0;
    end else begin
      sel_valid <= cyc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cyc_valid) begin
      sel <= dec;
    end
  end

endmodule

// File: address_map/rom_map.sv
`timescale 1ns/10ps

// Mapper-dependent classification and address translation
module rom_map import snes_map_pkg::*; (
  input  map_cfg_t   cfg,
  input  bus_cycle_t cyc,
  output logic       hit,
  output logic       saveram,
  output logic       writable,
  output mem_req_t   req
);

  logic        map_ok;
  logic        is_rom;
  logic        sram_hit;
  logic [23:0] rom_addr;
  logic [23:0] sram_off;
  logic [23:0] a;

  assign a = cyc.addr;

  ////////////////////////////////////////
  // Classification
  ////////////////////////////////////////

  always_comb begin
    map_ok   = 1'b1;
    sram_hit = 1'b0;
    case (cfg.mapper)
      MAP_LOROM, MAP_EXHIROM: begin
        sram_hit = !a[22] & a[21] & (&a[14:13]) & !a[15];
      end
      MAP_HIROM: begin
        sram_hit = (&a[22:20]) & !cyc.romsel_n & (!a[15] | !cfg.rom_mask[21]);
      end
      default: map_ok = 1'b0;  // Unknown mapper maps nothing
    endcase
  end

  assign is_rom   = map_ok & !cyc.romsel_n;
  assign saveram  = cfg.saveram_mask[0] & sram_hit;
  assign writable = saveram;
  assign hit      = is_rom | saveram;

  ////////////////////////////////////////
  // Translation
  ////////////////////////////////////////

  always_comb begin
    rom_addr = 24'h0;
    sram_off = 24'h0;
    case (cfg.mapper)
      MAP_LOROM: begin
        rom_addr = {1'b0, a[22:0]};
        sram_off = {6'b0, a[20:16], a[12:0]};
      end
      MAP_HIROM: begin
        rom_addr = {1'b0, a[23:16], a[14:0]};  // Drop bit 15
        sram_off = {4'b0, a[20:16], a[14:0]};
      end
      MAP_EXHIROM: begin
        rom_addr = {1'b0, !a[23], a[21:0]};
        sram_off = {6'b0, a[20:16], a[12:0]};
      end
      default: ;
    endcase
  end

  assign req.addr    = saveram ? SAVERAM_BASE + (sram_off & cfg.saveram_mask)
                               : rom_addr & cfg.rom_mask;
  assign req.saveram = saveram;
  assign req.wr      = cyc.wr;
  assign req.wdata   = cyc.wdata;

endmodule

// File: all.f
common/snes_map_pkg.sv
hdl/snes_bus_capture.sv
address_map/rom_map.sv
address_map/reg_decode.sv
hdl/mem_req_issue.sv
hdl/snes_map_top.sv
testbench/tb_clock.sv
testbench/snes_map_props.sv
testbench/tb_snes_map.sv

// File: common/snes_map_pkg.sv
package snes_map_pkg;

  ////////////////////////////////////////
  // Mapper and feature constants
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    MAP_LOROM   = 3'd0,
    MAP_HIROM   = 3'd1,
    MAP_EXHIROM = 3'd2
  } mapper_e;

  // Bit positions in featurebits
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;

  localparam logic [23:0] SAVERAM_BASE = 24'hE00000;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Static after reset
  typedef struct packed {
    logic [15:0] featurebits;
    mapper_e     mapper;
    logic [23:0] rom_mask;
    logic [23:0] saveram_mask;
  } map_cfg_t;

  // One console bus cycle as seen on the slot
  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  pa;       // B-bus address
    logic        romsel_n;
    logic        wr;
    logic [7:0]  wdata;
  } bus_cycle_t;

  typedef struct packed {
    logic msu;
    logic r213f;
    logic r2100;
    logic obc1;
    logic snescmd;
    logic nmicmd;
    logic return_vector;
    logic branch1;
    logic branch2;
    logic branch3;
  } periph_sel_t;

  // Request toward cartridge memory
  typedef struct packed {
    logic [23:0] addr;    // Translated
    logic        saveram;
    logic        wr;
    logic [7:0]  wdata;
  } mem_req_t;

endpackage

// File: hdl/mem_req_issue.sv
`timescale 1ns/10ps

// Request FIFO and credit counter toward the memory port
module mem_req_issue import snes_map_pkg::*; #(
  parameter int QUEUE_DEPTH = 4,
  parameter int MEM_CREDITS = 2
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enq,
  input  mem_req_t   enq_req,
  output logic       mem_req_valid,
  output mem_req_t   mem_req,
  input  logic       mem_credit,
  output logic [7:0] drop_count
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(MEM_CREDITS + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(QUEUE_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(QUEUE_DEPTH);
  localparam logic [CRD_W-1:0] CRD_MAX  = CRD_W'(MEM_CREDITS);

  mem_req_t         mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  logic             full, push, issue;

  assign full  = (count == CNT_FULL);
  assign push  = enq & !full;
  assign issue = mem_req_valid;  // No ready, valid is the issue

  assign mem_req_valid = (credits != '0) && (count != '0);
  assign mem_req       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= enq_req;
    end
  end

  ////////////////////////////////////////
  // Pointers, credits, drops
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credits    <= CRD_MAX;
      drop_count <= 8'h00;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (issue) rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      if (push && !issue) count <= count + 1'b1;
      else if (!push && issue) count <= count - 1'b1;
      // Simultaneous return and issue leaves the count alone
      if (issue && !mem_credit) begin
        credits <= credits - 1'b1;
      end else if (!issue && mem_credit && credits != CRD_MAX) begin
        credits <= credits + 1'b1;
      end
      if (enq && full && drop_count != 8'hFF) drop_count <= drop_count + 1'b1;  // Saturates
    end
  end

endmodule

// File: hdl/snes_bus_capture.sv
`timescale 1ns/10ps

// Registers one console bus cycle per strobe.
// The captured data only moves when a new strobe arrives, so the
// decode logic downstream sees no toggling between accesses.
module snes_bus_capture import snes_map_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       bus_valid,
  input  bus_cycle_t bus,
  output logic       cyc_valid,
  output bus_cycle_t cyc
);

  ////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_valid <= 1'b0;
    end else begin
      cyc_valid <= bus_valid;  // One cycle per strobe
    end
  end

  ////////////////////////////////////////
  // Cycle payload
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (bus_valid) begin
      cyc <= bus;
    end
  end

endmodule

// File: hdl/snes_map_top.sv
`timescale 1ns/10ps

module snes_map_top import snes_map_pkg::*; #(
  parameter int QUEUE_DEPTH = 4,
  parameter int MEM_CREDITS = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  map_cfg_t    cfg,
  input  logic        bus_valid,
  input  bus_cycle_t  bus,
  output logic        sel_valid,
  output periph_sel_t sel,
  output logic        mem_req_valid,
  output mem_req_t    mem_req,
  input  logic        mem_credit,
  output logic [7:0]  drop_count
);

  logic       cyc_valid;
  bus_cycle_t cyc;
  logic       hit, writable;
  mem_req_t   req;

  // Writes outside save RAM never reach memory
  wire enq = cyc_valid & hit & ~(cyc.wr & ~writable);

  snes_bus_capture snes_bus_capture_i (
    .clk, .rst_n, .bus_valid, .bus, .cyc_valid, .cyc
  );

  rom_map rom_map_i (
    .cfg, .cyc, .hit, .saveram (), .writable, .req
  );

  reg_decode reg_decode_i (
    .clk, .rst_n, .cfg, .cyc_valid, .cyc, .sel_valid, .sel
  );

  mem_req_issue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .MEM_CREDITS (MEM_CREDITS)
  ) mem_req_issue_i (
    .clk, .rst_n, .enq, .enq_req (req), .mem_req_valid, .mem_req,
    .mem_credit, .drop_count
  );

endmodule

// File: testbench/snes_map_props.sv
`timescale 1ns/10ps

// Credit and queue properties of the request issue stage
module snes_map_props import snes_map_pkg::*; #(
  parameter int QUEUE_DEPTH = 4,
  parameter int MEM_CREDITS = 2
) (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               mem_req_valid,
  input mem_req_t                           mem_req,
  input logic                               mem_credit,
  input logic [$clog2(MEM_CREDITS + 1)-1:0] credits,
  input logic [$clog2(QUEUE_DEPTH + 1)-1:0] count
);

  int fails = 0;
  int in_flight;  // Requests awaiting their credit

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + (mem_req_valid ? 1 : 0) - (mem_credit ? 1 : 0);
    end
  end

  no_issue_without_credit: assert property (
    @(posedge clk) disable iff (!rst_n) mem_req_valid |-> in_flight < MEM_CREDITS
  ) else begin
    $error("memory request valid with zero credits");
    fails++;
  end

  credits_bounded: assert property (
    @(posedge clk) disable iff (!rst_n) credits <= MEM_CREDITS
  ) else begin
    $error("credit count above its initial value");
    fails++;
  end

  count_bounded: assert property (
    @(posedge clk) disable iff (!rst_n) count <= QUEUE_DEPTH
  ) else begin
    $error("queue occupancy above its depth");
    fails++;
  end

  // Head waits unchanged while credit is out
  head_held: assert property (
    @(posedge clk) disable iff (!rst_n)
      (count != '0 && credits == '0) |=> $stable(mem_req)
  ) else begin
    $error("queue head changed while waiting for credit");
    fails++;
  end

  req_known: assert property (
    @(posedge clk) disable iff (!rst_n) mem_req_valid |-> !$isunknown(mem_req)
  ) else begin
    $error("memory request carries unknown bits while valid");
    fails++;
  end

endmodule

bind mem_req_issue snes_map_props #(
  .QUEUE_DEPTH (QUEUE_DEPTH),
  .MEM_CREDITS (MEM_CREDITS)
) snes_map_props_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .mem_req_valid (mem_req_valid),
  .mem_req       (mem_req),
  .mem_credit    (mem_credit),
  .credits       (credits),
  .count         (count)
);

// File: testbench/tb_clock.sv
`timescale 1ns/10ps

// 10 ns clock, reset held low for the first 3 cycles
module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #5 clk = ~clk;

endmodule

// File: testbench/tb_snes_map.sv
`timescale 1ns/10ps

module tb_snes_map import snes_map_pkg::*; ();

  localparam int QUEUE_DEPTH = 4;
  localparam int MEM_CREDITS = 2;
  localparam int BURST_LEN   = QUEUE_DEPTH + MEM_CREDITS + 3;

  localparam map_cfg_t CFG_LO  = '{16'h0018, MAP_LOROM, 24'h3FFFFF, 24'h001FFF};
  localparam map_cfg_t CFG_LO0 = '{16'h0000, MAP_LOROM, 24'h3FFFFF, 24'h001FFF};
  localparam map_cfg_t CFG_NOS = '{16'h0018, MAP_LOROM, 24'h3FFFFF, 24'h001FFE};
  localparam map_cfg_t CFG_HI  = '{16'h0000, MAP_HIROM, 24'h3FFFFF, 24'h007FFF};
  localparam map_cfg_t CFG_EX  = '{16'h0018, MAP_EXHIROM, 24'h7FFFFF, 24'h001FFF};
  localparam map_cfg_t CFG_BAD = '{16'h0000, mapper_e'(3'd5), 24'h3FFFFF, 24'h001FFF};

  typedef struct packed {
    map_cfg_t    cfg;
    bus_cycle_t  bus;
    periph_sel_t sel;
    logic        has_req;
    mem_req_t    req;
    logic [7:0]  delay;  // Credit return delay
  } row_t;

  logic        clk, rst_n;
  map_cfg_t    cfg;
  logic        bus_valid;
  bus_cycle_t  bus;
  logic        sel_valid;
  periph_sel_t sel;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_credit;
  logic [7:0]  drop_count;

  row_t     rows[$];
  mem_req_t exp_q[$];
  int       delay_q[$];
  int       due_q[$];
  int       cycle, limit, outstanding;
  int       err_sel, err_req, err_drop, err_assert, err_other;
  logic     hold_credits;

  tb_clock tb_clock_i (.clk, .rst_n);

  snes_map_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .MEM_CREDITS (MEM_CREDITS)
  ) snes_map_top_i (
    .clk, .rst_n, .cfg, .bus_valid, .bus, .sel_valid, .sel,
    .mem_req_valid, .mem_req, .mem_credit, .drop_count
  );

  task automatic add_row(input map_cfg_t c, input logic [23:0] addr, input logic [7:0] pa,
                         input logic romsel_n, input logic wr, input logic [7:0] wdata,
                         input logic [9:0] s, input logic has_req,
                         input logic [23:0] raddr, input logic rsram, input int delay);
    row_t r;
    r.cfg     = c;
    r.bus     = '{addr, pa, romsel_n, wr, wdata};
    r.sel     = periph_sel_t'(s);
    r.has_req = has_req;
    r.req     = '{raddr, rsram, wr, wdata};
    r.delay   = 8'(delay);
    rows.push_back(r);
  endtask

  task automatic check_sel(input periph_sel_t got, input periph_sel_t exp);
    if (got !== exp) begin
      err_sel++;
      $display("FAIL %0t: select got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      err_req++;
      $display("FAIL %0t: request got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_drops(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      err_drop++;
      $display("FAIL %0t: drop count got %0d expected %0d", $time, got, exp);
    end
  endtask

  // Strobe one cycle, then look at the selects two edges later
  task automatic apply_row(input row_t r);
    @(posedge clk);
    cfg       <= r.cfg;
    bus       <= r.bus;
    bus_valid <= 1'b1;
    if (r.has_req) begin
      exp_q.push_back(r.req);
      delay_q.push_back(r.delay);
    end
    @(posedge clk);
    bus_valid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    if (sel_valid !== 1'b1) begin
      err_other++;
      $display("Select valid did not rise two cycles after the strobe at %0t", $time);
    end
    check_sel(sel, r.sel);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || due_q.size() != 0 || outstanding != 0) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // Memory model, credits and watchdog
  ////////////////////////////////////////

  always @(negedge clk) begin : monitor
    int d;
    if (rst_n) begin
      if (mem_credit) outstanding--;
      if (mem_req_valid) begin
        if (exp_q.size() == 0) begin
          err_other++;
          $display("Memory request %h issued with none expected at %0t", mem_req, $time);
          d = 2;
        end else begin
          check_req(mem_req, exp_q.pop_front());
          d = delay_q.pop_front();
        end
        due_q.push_back(cycle + d);
        outstanding++;
        if (outstanding > MEM_CREDITS) begin
          err_other++;
          $display("More requests outstanding than credits at %0t", $time);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    mem_credit <= 1'b0;
    if (rst_n && !hold_credits && due_q.size() != 0 && due_q[0] <= cycle) begin
      mem_credit <= 1'b1;
      void'(due_q.pop_front());
    end
    if (cycle >= limit) begin
      $display("Timeout after %0d cycles with requests still pending", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h45c7_a986));
    cfg          = CFG_LO;
    bus_valid    = 1'b0;
    bus          = '0;
    mem_credit   = 1'b0;
    hold_credits = 1'b0;
    cycle        = 0;
    outstanding  = 0;
    err_sel      = 0;
    err_req      = 0;
    err_drop     = 0;
    err_assert   = 0;
    err_other    = 0;
    // ROM reads, long credit delays so later ones wait
    add_row(CFG_LO, 24'h808123, 8'h80, 0, 0, 8'h00, 10'h000, 1, 24'h008123, 0, 12);
    add_row(CFG_LO, 24'hC01234, 8'h80, 0, 0, 8'h00, 10'h000, 1, 24'h001234, 0, 12);
    add_row(CFG_HI, 24'hC18765, 8'h80, 0, 0, 8'h00, 10'h000, 1, 24'h208765, 0, 3);
    add_row(CFG_EX, 24'h401234, 8'h80, 0, 0, 8'h00, 10'h000, 1, 24'h401234, 0, 3);
    add_row(CFG_EX, 24'hC05678, 8'h80, 0, 0, 8'h00, 10'h000, 1, 24'h005678, 0, 1);
    // Save RAM
    add_row(CFG_LO, 24'h306010, 8'h80, 1, 0, 8'h00, 10'h000, 1, 24'hE00010, 1, 4);
    add_row(CFG_LO, 24'h307FFF, 8'h80, 1, 1, 8'hA5, 10'h040, 1, 24'hE01FFF, 1, 2);
    add_row(CFG_HI, 24'h706123, 8'h80, 0, 0, 8'h00, 10'h000, 1, 24'hE06123, 1, 6);
    add_row(CFG_HI, 24'h710042, 8'h80, 0, 1, 8'h3C, 10'h000, 1, 24'hE00042, 1, 2);
    add_row(CFG_EX, 24'h306ABC, 8'h80, 1, 0, 8'h00, 10'h000, 1, 24'hE00ABC, 1, 3);
    // No request
    add_row(CFG_NOS, 24'h306011, 8'h80, 1, 0, 8'h00, 10'h000, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h809000, 8'h80, 0, 1, 8'h77, 10'h000, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h001000, 8'h80, 1, 0, 8'h00, 10'h000, 0, 24'h0, 0, 0);
    add_row(CFG_BAD, 24'h808000, 8'h80, 0, 0, 8'h00, 10'h000, 0, 24'h0, 0, 0);
    // Selects
    add_row(CFG_LO, 24'h002003, 8'h80, 1, 0, 8'h00, 10'h200, 0, 24'h0, 0, 0);
    add_row(CFG_LO0, 24'h002003, 8'h80, 1, 0, 8'h00, 10'h000, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h001000, 8'h3F, 1, 0, 8'h00, 10'h100, 0, 24'h0, 0, 0);
    add_row(CFG_LO0, 24'h001000, 8'h3F, 1, 0, 8'h00, 10'h000, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h001000, 8'h00, 1, 0, 8'h00, 10'h080, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h002A00, 8'h80, 1, 0, 8'h00, 10'h020, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h002BF2, 8'h80, 1, 0, 8'h00, 10'h030, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h002A6C, 8'h80, 1, 0, 8'h00, 10'h028, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h002A1F, 8'h80, 1, 0, 8'h00, 10'h024, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h002A59, 8'h80, 1, 0, 8'h00, 10'h022, 0, 24'h0, 0, 0);
    add_row(CFG_LO, 24'h002A5E, 8'h80, 1, 0, 8'h00, 10'h021, 0, 24'h0, 0, 0);
    limit = (rows.size() + BURST_LEN) * 40;
    @(posedge rst_n);
    foreach (rows[i]) begin
      apply_row(rows[i]);
      repeat ($urandom_range(3, 0)) @(posedge clk);
    end
    wait_drain();
    @(negedge clk);
    check_drops(drop_count, 8'd0);

    ////////////////////////////////////////
    // Burst with credits withheld
    ////////////////////////////////////////
    hold_credits = 1'b1;
    for (int i = 0; i < BURST_LEN; i++) begin
      @(posedge clk);
      cfg       <= CFG_LO;
      bus       <= '{24'h808000 + 24'(i), 8'h80, 1'b0, 1'b0, 8'h00};
      bus_valid <= 1'b1;
      if (i < QUEUE_DEPTH + MEM_CREDITS) begin
        exp_q.push_back(mem_req_t'{24'h008000 + 24'(i), 1'b0, 1'b0, 8'h00});
        delay_q.push_back(2);
      end
    end
    @(posedge clk);
    bus_valid <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_drops(drop_count, 8'd3);
    hold_credits = 1'b0;
    wait_drain();

    err_assert = snes_map_top_i.mem_req_issue_i.snes_map_props_i.fails;
    $display("Errors: select %0d, request %0d, drops %0d, assertion %0d, other %0d",
             err_sel, err_req, err_drop, err_assert, err_other);
    if (err_sel + err_req + err_drop + err_assert + err_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
